//--- tower_pkg.sv
package tower_pkg;
	localparam int NUM_IDS = 16;
	localparam int NUM_RUNWAYS = 2;

	typedef logic [3:0] plane_id_t;

	// Byte layout is {plane id, kind, action}.
	typedef logic [7:0] msg_t;

	typedef enum logic [2:0] {
		msg_request   = 3'b000,
		msg_release   = 3'b001,
		msg_clear     = 3'b011,
		msg_hold      = 3'b100,
		msg_say_again = 3'b101,
		msg_divert    = 3'b110,
		msg_id_assign = 3'b111
	} msg_kind_t;

	typedef enum logic [2:0] {
		idle,
		decode,
		queue_reply,
		schedule,
		clear_takeoff,
		clear_landing,
		post_clear
	} ctrl_state_t;
endpackage

//--- runway_bus_if.sv
`timescale 1ns/1ps
interface runway_bus_if;
	import tower_pkg::*;

	logic [NUM_RUNWAYS-1:0] lock; // One-cycle strobes.
	logic [NUM_RUNWAYS-1:0] unlock;
	plane_id_t lock_id;
	plane_id_t unlock_id;
	plane_id_t occupant [NUM_RUNWAYS];
	logic [NUM_RUNWAYS-1:0] busy;

	modport controller (
		output lock, unlock, lock_id, unlock_id,
		input occupant, busy
	);

	modport slot (
		input lock, unlock, lock_id, unlock_id,
		output occupant, busy
	);
endinterface

//--- uart_rx.sv
`timescale 1ns/1ps
module uart_rx #(
	parameter int CLK_HZ = 25_000_000,
	parameter int BAUD_RATE = 115_200
) (
	input logic clock,
	input logic reset,
	input logic rx,
	output tower_pkg::msg_t data,
	output logic done,
	output logic framing_error
);
	localparam int DIVISOR = CLK_HZ / BAUD_RATE;
	localparam int CNT_W = $clog2(DIVISOR);

	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_error} rx_state_t;

	rx_state_t state;
	logic [CNT_W-1:0] timer;
	logic [3:0] bit_count;
	logic [7:0] shift;
	logic tick;

	assign tick = (timer == '0);
	assign data = shift;
	// Stop bit sample with the line high.
	assign done = (state == rx_data) && tick && (bit_count == 4'd8) && rx;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= rx_idle;
			timer <= '0;
			bit_count <= '0;
			framing_error <= 1'b0;
		end else begin
			timer <= tick ? CNT_W'(DIVISOR - 1) : timer - 1'b1;
			case (state)
				rx_idle: begin
					if (!rx) begin
						timer <= CNT_W'(DIVISOR / 2 - 1); // Sample mid-bit.
						state <= rx_start;
					end
				end
				rx_start: begin
					if (tick) begin
						bit_count <= '0;
						state <= rx ? rx_idle : rx_data; // Glitch, not a start bit.
					end
				end
				rx_data: begin
					if (tick) begin
						if (bit_count == 4'd8) begin
							framing_error <= !rx;
							state <= rx ? rx_idle : rx_error;
						end else begin
							bit_count <= bit_count + 1'b1;
						end
					end
				end
				rx_error: begin
					if (tick && rx) begin
						framing_error <= 1'b0;
						state <= rx_idle;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// LSB arrives first.
	always_ff @(posedge clock) begin
		if (state == rx_data && tick && bit_count != 4'd8)
			shift <= {rx, shift[7:1]};
	end
endmodule

//--- uart_tx.sv
`timescale 1ns/1ps
module uart_tx #(
	parameter int CLK_HZ = 25_000_000,
	parameter int BAUD_RATE = 115_200
) (
	input logic clock,
	input logic reset,
	input tower_pkg::msg_t data,
	input logic empty,
	output logic pop,
	output logic tx
);
	localparam int DIVISOR = CLK_HZ / BAUD_RATE;
	localparam int CNT_W = $clog2(DIVISOR);

	typedef enum logic [2:0] {tx_idle, tx_load, tx_start, tx_data, tx_stop} tx_state_t;

	tx_state_t state;
	logic [CNT_W-1:0] timer;
	logic [2:0] bit_count;
	logic [7:0] shift;
	logic tick;

	assign tick = (timer == '0);
	assign pop = (state == tx_idle) && !empty;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= tx_idle;
			tx <= 1'b1;
			timer <= '0;
			bit_count <= '0;
		end else begin
			timer <= tick ? CNT_W'(DIVISOR - 1) : timer - 1'b1;
			case (state)
				tx_idle: begin
					if (!empty) begin
						// Start bit covers the load cycle too.
						timer <= CNT_W'(DIVISOR - 1);
						tx <= 1'b0;
						state <= tx_load;
					end
				end
				tx_load: state <= tx_start; // Queue output valid now.
				tx_start: begin
					if (tick) begin
						tx <= shift[0];
						bit_count <= '0;
						state <= tx_data;
					end
				end
				tx_data: begin
					if (tick) begin
						if (bit_count == 3'd7) begin
							tx <= 1'b1;
							state <= tx_stop;
						end else begin
							tx <= shift[0];
							bit_count <= bit_count + 1'b1;
						end
					end
				end
				tx_stop: begin
					if (tick)
						state <= tx_idle;
				end
				default: state <= tx_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == tx_load)
			shift <= data;
		else if (tick && (state == tx_start || state == tx_data))
			shift <= shift >> 1;
	end
endmodule

//--- plane_queue.sv
`timescale 1ns/1ps
module plane_queue #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input logic clock,
	input logic reset,
	input logic [WIDTH-1:0] data_in,
	input logic push,
	input logic pop,
	output logic [WIDTH-1:0] data,
	output logic full,
	output logic empty
);
	localparam int PTR_W = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W:0] count;
	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign full = (count == (PTR_W + 1)'(DEPTH));
	assign do_push = push && !full; // Dropped when full.
	assign do_pop = pop && !empty;

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
		if (do_pop)
			data <= mem[rd_ptr]; // Head shows up the cycle after pop.
	end
endmodule

//--- aircraft_id_pool.sv
`timescale 1ns/1ps
module aircraft_id_pool (
	input logic clock,
	input logic reset,
	input tower_pkg::plane_id_t id_in,
	input logic take,
	input logic free,
	output logic [tower_pkg::NUM_IDS-1:0] all_taken,
	output tower_pkg::plane_id_t next_free,
	output logic full
);
	import tower_pkg::*;

	assign full = &all_taken;

	// Lowest free ID wins.
	always_comb begin
		next_free = '0;
		for (int i = NUM_IDS - 1; i >= 0; i--) begin
			if (!all_taken[i])
				next_free = plane_id_t'(i);
		end
	end

	always_ff @(posedge clock) begin
		if (reset)
			all_taken <= '0;
		else if (free)
			all_taken[id_in] <= 1'b0;
		else if (take && !full)
			all_taken[next_free] <= 1'b1;
	end
endmodule

//--- runway_slot.sv
`timescale 1ns/1ps
module runway_slot #(
	parameter int INDEX = 0
) (
	input logic clock,
	input logic reset,
	runway_bus_if.slot bus
);
	import tower_pkg::*;

	plane_id_t occupant;
	logic busy;

	assign bus.occupant[INDEX] = occupant;
	assign bus.busy[INDEX] = busy;

	always_ff @(posedge clock) begin
		if (reset)
			busy <= 1'b0;
		else if (bus.lock[INDEX])
			busy <= 1'b1;
		else if (bus.unlock[INDEX] && bus.unlock_id == occupant)
			busy <= 1'b0; // Only the plane on it may free it.
	end

	always_ff @(posedge clock) begin
		if (bus.lock[INDEX])
			occupant <= bus.lock_id;
	end
endmodule

//--- tower_controller.sv
`timescale 1ns/1ps
module tower_controller (
	input logic clock,
	input logic reset,
	input tower_pkg::msg_t request,
	input logic request_empty,
	output logic request_pop,
	output logic takeoff_push,
	output logic takeoff_pop,
	input tower_pkg::plane_id_t takeoff_head,
	input logic takeoff_full,
	input logic takeoff_empty,
	output logic landing_push,
	output logic landing_pop,
	input tower_pkg::plane_id_t landing_head,
	input logic landing_full,
	input logic landing_empty,
	input logic [tower_pkg::NUM_IDS-1:0] id_taken,
	input tower_pkg::plane_id_t next_free,
	input logic id_full,
	output logic id_take,
	output logic id_free,
	output tower_pkg::msg_t reply,
	output logic reply_push,
	input logic reply_full,
	runway_bus_if.controller runway
);
	import tower_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;
	plane_id_t req_id;
	msg_kind_t req_kind;
	logic req_action;
	logic req_queue_full;
	logic takeoff_first;
	logic any_free;
	logic free_idx;
	logic pick_takeoff;
	logic can_clear;

	assign req_id = request[7:4];
	assign req_kind = msg_kind_t'(request[3:1]);
	assign req_action = request[0]; // Landing, or runway number on release.
	assign req_queue_full = req_action ? landing_full : takeoff_full;

	always_comb begin
		any_free = 1'b0;
		free_idx = 1'b0;
		for (int r = NUM_RUNWAYS - 1; r >= 0; r--) begin
			if (!runway.busy[r]) begin
				any_free = 1'b1;
				free_idx = r[0];
			end
		end
	end

	// Room for the clearance reply is checked up front.
	assign can_clear = any_free && !(takeoff_empty && landing_empty) && !reply_full;
	assign pick_takeoff = !takeoff_empty && (landing_empty || takeoff_first);

	assign runway.lock_id = (state == clear_takeoff) ? takeoff_head : landing_head;
	assign runway.unlock_id = req_id;

	always_comb begin
		next_state = state;
		request_pop = 1'b0;
		takeoff_push = 1'b0;
		takeoff_pop = 1'b0;
		landing_push = 1'b0;
		landing_pop = 1'b0;
		id_take = 1'b0;
		id_free = 1'b0;
		reply_push = 1'b0;
		runway.lock = '0;
		runway.unlock = '0;
		case (state)
			idle: begin
				if (!request_empty) begin
					request_pop = 1'b1;
					next_state = decode;
				end else if (can_clear) begin
					next_state = schedule;
				end
			end
			decode: begin
				next_state = queue_reply;
				case (req_kind)
					msg_request: begin
						if (!id_taken[req_id])
							next_state = schedule; // Unknown plane, no answer.
						else if (req_queue_full)
							id_free = 1'b1; // Diverted.
						else if (req_action)
							landing_push = 1'b1;
						else
							takeoff_push = 1'b1;
					end
					msg_release: begin
						next_state = schedule;
						if (runway.busy[req_action] && runway.occupant[req_action] == req_id) begin
							runway.unlock[req_action] = 1'b1;
							id_free = 1'b1;
						end
					end
					msg_id_assign: id_take = !id_full;
					default: ;
				endcase
			end
			queue_reply: begin
				if (!reply_full) begin
					reply_push = 1'b1;
					next_state = schedule;
				end
			end
			schedule: begin
				next_state = idle;
				if (can_clear) begin
					if (pick_takeoff) begin
						takeoff_pop = 1'b1;
						next_state = clear_takeoff;
					end else begin
						landing_pop = 1'b1;
						next_state = clear_landing;
					end
				end
			end
			clear_takeoff, clear_landing: begin
				runway.lock[free_idx] = 1'b1;
				next_state = post_clear;
			end
			post_clear: begin
				reply_push = 1'b1;
				next_state = idle;
			end
			default: next_state = idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			takeoff_first <= 1'b0;
		end else begin
			state <= next_state;
			if (state == schedule && can_clear && !takeoff_empty && !landing_empty)
				takeoff_first <= !takeoff_first; // Alternate only under contention.
		end
	end

	always_ff @(posedge clock) begin
		if (state == decode) begin
			case (req_kind)
				msg_request: reply <= {req_id, req_queue_full ? msg_divert : msg_hold, 1'b0};
				msg_id_assign: begin
					if (id_full)
						reply <= {plane_id_t'(0), msg_id_assign, 1'b1};
					else
						reply <= {next_free, msg_id_assign, 1'b0};
				end
				default: reply <= {req_id, msg_say_again, 1'b0};
			endcase
		end else if (state == clear_takeoff || state == clear_landing) begin
			reply <= {runway.lock_id, msg_clear, free_idx};
		end
	end
endmodule

//--- tower_top.sv
`timescale 1ns/1ps
module tower_top #(
	parameter int CLK_HZ = 25_000_000,
	parameter int BAUD_RATE = 115_200
) (
	input logic clock,
	input logic reset,
	input logic rx,
	output logic tx,
	output logic framing_error,
	output logic [tower_pkg::NUM_RUNWAYS-1:0] runway_active
);
	import tower_pkg::*;

	msg_t rx_data;
	logic rx_done;
	msg_t request;
	logic request_empty;
	logic request_pop;
	plane_id_t request_id;
	logic takeoff_push;
	logic takeoff_pop;
	plane_id_t takeoff_head;
	logic takeoff_full;
	logic takeoff_empty;
	logic landing_push;
	logic landing_pop;
	plane_id_t landing_head;
	logic landing_full;
	logic landing_empty;
	logic [NUM_IDS-1:0] id_taken;
	plane_id_t next_free;
	logic id_full;
	logic id_take;
	logic id_free;
	msg_t reply;
	logic reply_push;
	logic reply_full;
	msg_t tx_data;
	logic tx_pop;
	logic reply_empty;

	runway_bus_if runway_bus ();

	assign request_id = request[7:4];
	assign runway_active = runway_bus.busy;

	uart_rx #(
		.CLK_HZ(CLK_HZ),
		.BAUD_RATE(BAUD_RATE)
	) uart_rx_inst (
		.clock(clock),
		.reset(reset),
		.rx(rx),
		.data(rx_data),
		.done(rx_done),
		.framing_error(framing_error)
	);

	// Bytes arriving while this is full are lost.
	plane_queue #(.WIDTH(8), .DEPTH(4)) rx_buffer (
		.clock(clock),
		.reset(reset),
		.data_in(rx_data),
		.push(rx_done),
		.pop(request_pop),
		.data(request),
		.full(),
		.empty(request_empty)
	);

	plane_queue #(.WIDTH(4), .DEPTH(8)) takeoff_queue (
		.clock(clock),
		.reset(reset),
		.data_in(request_id),
		.push(takeoff_push),
		.pop(takeoff_pop),
		.data(takeoff_head),
		.full(takeoff_full),
		.empty(takeoff_empty)
	);

	plane_queue #(.WIDTH(4), .DEPTH(8)) landing_queue (
		.clock(clock),
		.reset(reset),
		.data_in(request_id),
		.push(landing_push),
		.pop(landing_pop),
		.data(landing_head),
		.full(landing_full),
		.empty(landing_empty)
	);

	aircraft_id_pool id_pool (
		.clock(clock),
		.reset(reset),
		.id_in(request_id),
		.take(id_take),
		.free(id_free),
		.all_taken(id_taken),
		.next_free(next_free),
		.full(id_full)
	);

	tower_controller controller (
		.clock(clock),
		.reset(reset),
		.request(request),
		.request_empty(request_empty),
		.request_pop(request_pop),
		.takeoff_push(takeoff_push),
		.takeoff_pop(takeoff_pop),
		.takeoff_head(takeoff_head),
		.takeoff_full(takeoff_full),
		.takeoff_empty(takeoff_empty),
		.landing_push(landing_push),
		.landing_pop(landing_pop),
		.landing_head(landing_head),
		.landing_full(landing_full),
		.landing_empty(landing_empty),
		.id_taken(id_taken),
		.next_free(next_free),
		.id_full(id_full),
		.id_take(id_take),
		.id_free(id_free),
		.reply(reply),
		.reply_push(reply_push),
		.reply_full(reply_full),
		.runway(runway_bus)
	);

	for (genvar r = 0; r < NUM_RUNWAYS; r++) begin : g_runway
		runway_slot #(.INDEX(r)) slot (
			.clock(clock),
			.reset(reset),
			.bus(runway_bus)
		);
	end

	plane_queue #(.WIDTH(8), .DEPTH(4)) reply_buffer (
		.clock(clock),
		.reset(reset),
		.data_in(reply),
		.push(reply_push),
		.pop(tx_pop),
		.data(tx_data),
		.full(reply_full),
		.empty(reply_empty)
	);

	uart_tx #(
		.CLK_HZ(CLK_HZ),
		.BAUD_RATE(BAUD_RATE)
	) uart_tx_inst (
		.clock(clock),
		.reset(reset),
		.data(tx_data),
		.empty(reply_empty),
		.pop(tx_pop),
		.tx(tx)
	);
endmodule

//--- tower_chk.sv
`timescale 1ns/1ps
module tower_chk (
	input logic clock,
	input logic reset,
	input logic push,
	input logic full,
	input logic pop,
	input logic empty,
	input logic [tower_pkg::NUM_RUNWAYS-1:0] lock,
	input logic [tower_pkg::NUM_RUNWAYS-1:0] busy
);
	push_not_full: assert property (@(posedge clock) disable iff (reset) push |-> !full)
		else $error("push accepted while full");

	pop_not_empty: assert property (@(posedge clock) disable iff (reset) pop |-> !empty)
		else $error("pop accepted while empty");

	// A runway is only locked while it is free.
	lock_free_runway: assert property (@(posedge clock) disable iff (reset) (lock & busy) == '0)
		else $error("lock issued for a busy runway");
endmodule

// Reply pushes, request pops and runway locks of the controller.
bind tower_controller tower_chk controller_chk (
	.clock(clock),
	.reset(reset),
	.push(reply_push),
	.full(reply_full),
	.pop(request_pop),
	.empty(request_empty),
	.lock(runway.lock),
	.busy(runway.busy)
);

// Strobes as the producer and consumer drive them.
bind plane_queue tower_chk queue_chk (
	.clock(clock),
	.reset(reset),
	.push(push),
	.full(full),
	.pop(pop),
	.empty(empty),
	.lock('0),
	.busy('0)
);

//--- tb_tower.sv
`timescale 1ns/1ps
module tb_tower;
	import tower_pkg::*;

	localparam int CLOCK_PERIOD = 4;
	localparam int BIT_CYCLES = 10;
	localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
	localparam int QUIET_CYCLES = 4 * BIT_CYCLES;
	localparam int QUEUE_DEPTH = 8;
	localparam int RANDOM_BYTES = 40;
	localparam int NUM_BYTES = 42 + RANDOM_BYTES;
	// One frame in, two replies out, the quiet wait and some margin.
	localparam int BYTE_BUDGET_NS = (4 * FRAME_CYCLES + QUIET_CYCLES) * CLOCK_PERIOD;
	localparam int WATCHDOG_NS = (NUM_BYTES + 2) * BYTE_BUDGET_NS;

	logic clock;
	logic reset;
	logic rx;
	logic tx;
	logic framing_error;
	logic [NUM_RUNWAYS-1:0] runway_active;

	// Reference model state.
	logic [NUM_IDS-1:0] m_taken = '0;
	plane_id_t m_takeoff [$];
	plane_id_t m_landing [$];
	logic [NUM_RUNWAYS-1:0] m_busy = '0;
	plane_id_t m_occ [NUM_RUNWAYS] = '{default: '0};
	logic m_takeoff_first = 1'b0; // Landing goes first.

	msg_t exp_q [$];
	msg_t got_q [$];
	logic tx_receiving = 1'b0;
	logic [31:0] lcg_state = 32'h0968_1a06;

	tower_top #(
		.CLK_HZ(250_000_000),
		.BAUD_RATE(25_000_000)
	) tower_top_inst (
		.clock(clock),
		.reset(reset),
		.rx(rx),
		.tx(tx),
		.framing_error(framing_error),
		.runway_active(runway_active)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped after a failure");
	endtask

	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected)
			fail_run($sformatf("error: time %0t, %s = %h, expected %h",
				$time, name, got, expected));
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Expected replies for one request byte, then any clearances it allows.
	function automatic void predict_replies(input msg_t b);
		plane_id_t id;
		logic [2:0] kind;
		logic act;
		plane_id_t free_id;
		int r;
		logic use_takeoff;
		id = b[7:4];
		kind = b[3:1];
		act = b[0];
		case (kind)
			msg_id_assign: begin
				if (&m_taken) begin
					exp_q.push_back({4'd0, msg_id_assign, 1'b1});
				end else begin
					free_id = '0;
					for (int i = NUM_IDS - 1; i >= 0; i--)
						if (!m_taken[i])
							free_id = 4'(i);
					m_taken[free_id] = 1'b1;
					exp_q.push_back({free_id, msg_id_assign, 1'b0});
				end
			end
			msg_request: begin
				if (m_taken[id]) begin
					if ((act ? m_landing.size() : m_takeoff.size()) == QUEUE_DEPTH) begin
						m_taken[id] = 1'b0;
						exp_q.push_back({id, msg_divert, 1'b0});
					end else begin
						exp_q.push_back({id, msg_hold, 1'b0});
						if (act)
							m_landing.push_back(id);
						else
							m_takeoff.push_back(id);
					end
				end
			end
			msg_release: begin
				if (m_busy[act] && m_occ[act] == id) begin
					m_busy[act] = 1'b0;
					m_taken[id] = 1'b0;
				end
			end
			default: exp_q.push_back({id, msg_say_again, 1'b0});
		endcase
		while (!(&m_busy) && (m_takeoff.size() + m_landing.size()) > 0) begin
			r = m_busy[0] ? 1 : 0; // Lowest free runway.
			if (m_takeoff.size() > 0 && m_landing.size() > 0) begin
				use_takeoff = m_takeoff_first;
				m_takeoff_first = !m_takeoff_first;
			end else begin
				use_takeoff = (m_takeoff.size() > 0);
			end
			if (use_takeoff)
				id = m_takeoff.pop_front();
			else
				id = m_landing.pop_front();
			m_busy[r] = 1'b1;
			m_occ[r] = id;
			exp_q.push_back({id, msg_clear, r[0]});
		end
	endfunction

	task automatic drive_bit(input logic value);
		#1 rx = value;
		repeat (BIT_CYCLES) @(posedge clock);
	endtask

	task automatic send_frame(input msg_t b, input logic stop_bit);
		@(posedge clock);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++)
			drive_bit(b[i]);
		drive_bit(stop_bit);
		#1 rx = 1'b1;
		check_equal("framing_error", 32'(framing_error), 32'(!stop_bit));
	endtask

	// Returns once tx has been idle for a few bit times.
	task automatic wait_quiet();
		int quiet;
		quiet = 0;
		while (quiet < QUIET_CYCLES) begin
			@(negedge clock);
			if (tx && !tx_receiving)
				quiet++;
			else
				quiet = 0;
		end
	endtask

	task automatic send_byte(input msg_t b);
		predict_replies(b);
		send_frame(b, 1'b1);
		wait_quiet();
		if (exp_q.size() != 0)
			fail_run($sformatf("a reply is missing after request byte %h", b));
		check_equal("runway_active", 32'(runway_active), 32'(m_busy));
	endtask

	// Serial monitor, samples each tx bit in its middle.
	initial begin
		msg_t rx_byte;
		forever begin
			@(negedge clock);
			if (!reset && !tx) begin
				tx_receiving = 1'b1;
				repeat (BIT_CYCLES / 2) @(negedge clock);
				if (tx)
					fail_run("tx start bit went high before its middle");
				for (int i = 0; i < 8; i++) begin
					repeat (BIT_CYCLES) @(negedge clock);
					rx_byte[i] = tx;
				end
				repeat (BIT_CYCLES) @(negedge clock);
				if (!tx)
					fail_run("tx stop bit is low");
				got_q.push_back(rx_byte);
				tx_receiving = 1'b0;
			end
		end
	end

	initial begin
		msg_t got;
		msg_t expected;
		forever begin
			@(negedge clock);
			while (got_q.size() > 0) begin
				if (exp_q.size() == 0)
					fail_run($sformatf("tx sent %h when no reply was expected", got_q[0]));
				got = got_q.pop_front();
				expected = exp_q.pop_front();
				check_equal("tx reply", 32'(got), 32'(expected));
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run("watchdog expired before all requests were answered");
	end

	initial begin
		logic [31:0] rnd;
		msg_t b;
		rx = 1'b1;
		reset = 1'b1;
		repeat (5) @(posedge clock);
		#1 reset = 1'b0;

		for (int i = 0; i < 17; i++)
			send_byte({4'(i), msg_id_assign, 1'b0}); // Last one finds the pool full.

		send_byte({4'd1, msg_request, 1'b0});
		send_byte({4'd2, msg_request, 1'b1});
		for (int i = 3; i <= 11; i++)
			send_byte({4'(i), msg_request, 1'b0}); // Plane 11 is diverted.
		send_byte({4'd0, msg_id_assign, 1'b0});
		send_byte({4'd12, msg_request, 1'b1});
		send_byte({4'd13, msg_request, 1'b1});

		send_byte({4'd1, msg_release, 1'b0});
		send_byte({4'd5, msg_release, 1'b1}); // Not the occupant.
		send_byte({4'd2, msg_release, 1'b1});
		send_byte({4'd1, msg_request, 1'b0});

		for (int k = 2; k <= 6; k++) begin
			rnd = lcg_next();
			send_byte({rnd[31:28], 3'(k), rnd[27]});
		end

		send_frame({4'd3, msg_request, 1'b0}, 1'b0);
		wait_quiet();
		check_equal("framing_error", 32'(framing_error), 32'd0);
		send_byte({4'd0, msg_id_assign, 1'b0});

		for (int n = 0; n < RANDOM_BYTES; n++) begin
			rnd = lcg_next();
			if (rnd[17:16] == 2'b00)
				b = {m_occ[rnd[18]], msg_release, rnd[18]}; // Occupant leaves.
			else
				b = rnd[31:24];
			send_byte(b);
		end

		if (exp_q.size() == 0 && got_q.size() == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			fail_run("replies were left unchecked at the end of the run");
		end
	end
endmodule

//--- project.f
tower_pkg.sv
runway_bus_if.sv
uart_rx.sv
uart_tx.sv
plane_queue.sv
aircraft_id_pool.sv
runway_slot.sv
tower_controller.sv
tower_top.sv
tower_chk.sv
tb_tower.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_tower
FILE_LIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
